// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG) || ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+include
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_registers.sv
hdl/rv_alu.sv
hdl/rv_exec_ctrl.sv
hdl/rv_core.sv
verif/rv_core_asserts.sv
verif/rv_core_tb.sv

// ==== hdl/rv_alu.sv ====
`default_nettype none

module rv_alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_t op,
    output rv_pkg::word_t   result
);

    logic lt_signed;

    assign lt_signed = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD: begin
                result = a + b; // Wraps at 32 bits
            end
            rv_pkg::ALU_SUB: begin
                result = a - b;
            end
            rv_pkg::ALU_AND: begin
                result = a & b;
            end
            rv_pkg::ALU_OR: begin
                result = a | b;
            end
            rv_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            rv_pkg::ALU_SLT: begin
                result = {31'b0, lt_signed};
            end
            default: begin
                result = a + b;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
`default_nettype none

module rv_core (
    input  logic          clk,
    input  logic          rst,

    // Instruction port
    output logic          ibus_cyc,
    output logic          ibus_stb,
    output rv_pkg::addr_t ibus_adr,
    input  rv_pkg::word_t ibus_dat_r,
    input  logic          ibus_ack,

    // Data port, sel is implied all ones
    output logic          dbus_cyc,
    output logic          dbus_stb,
    output logic          dbus_we,
    output rv_pkg::addr_t dbus_adr,
    output rv_pkg::word_t dbus_dat_w,
    input  rv_pkg::word_t dbus_dat_r,
    input  logic          dbus_ack
);

    rv_pkg::word_t    instr;
    logic             instr_valid;
    logic             fetch_next;
    rv_pkg::word_t    lui_value;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    logic             rs_en;
    logic             rd_en;
    rv_pkg::wsel_t    wsel;
    rv_pkg::word_t    rdata1;
    rv_pkg::word_t    rdata2;
    rv_pkg::word_t    alu_a;
    rv_pkg::word_t    alu_b;
    rv_pkg::alu_op_t  alu_op;
    rv_pkg::word_t    alu_result;
    rv_pkg::word_t    load_data;

    rv_fetch fetch_i (
        .clk, .rst, .fetch_next,
        .ibus_cyc, .ibus_stb, .ibus_adr, .ibus_dat_r, .ibus_ack,
        .instr, .instr_valid, .lui_value
    );

    rv_registers regs_i (
        .clk, .rst, .rs1, .rs2, .rd, .rs_en, .rd_en, .wsel,
        .wdata_mem   (load_data),
        .wdata_fetch (lui_value),
        .wdata_alu   (alu_result), // Still valid in WRITEBACK
        .rdata1, .rdata2
    );

    rv_alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    rv_exec_ctrl ctrl_i (
        .clk, .rst, .instr, .instr_valid, .fetch_next,
        .rs1, .rs2, .rd, .rs_en, .rd_en, .wsel, .rdata1, .rdata2,
        .alu_a, .alu_b, .alu_op, .alu_result,
        .dbus_cyc, .dbus_stb, .dbus_we, .dbus_adr, .dbus_dat_w, .dbus_dat_r, .dbus_ack,
        .load_data
    );

endmodule

`default_nettype wire

// ==== hdl/rv_exec_ctrl.sv ====
`default_nettype none

`include "rv_defines.svh"

module rv_exec_ctrl (
    input  logic             clk,
    input  logic             rst,

    input  rv_pkg::word_t    instr,
    input  logic             instr_valid,
    output logic             fetch_next,

    // Register file control
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::reg_idx_t rd,
    output logic             rs_en,
    output logic             rd_en,
    output rv_pkg::wsel_t    wsel,
    input  rv_pkg::word_t    rdata1,
    input  rv_pkg::word_t    rdata2,

    // ALU
    output rv_pkg::word_t    alu_a,
    output rv_pkg::word_t    alu_b,
    output rv_pkg::alu_op_t  alu_op,
    input  rv_pkg::word_t    alu_result,

    // Wishbone classic data master
    output logic             dbus_cyc,
    output logic             dbus_stb,
    output logic             dbus_we,
    output rv_pkg::addr_t    dbus_adr,
    output rv_pkg::word_t    dbus_dat_w,
    input  rv_pkg::word_t    dbus_dat_r,
    input  logic             dbus_ack,

    output rv_pkg::word_t    load_data  // To the memory write source
);

    rv_pkg::exec_state_t state;
    rv_pkg::exec_state_t state_nxt;

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    logic          mem_req;    // LW or SW
    logic          mem_store;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // Sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    // Decode, anything unrecognised leaves wsel at NONE
    always_comb begin
        alu_a     = rdata1;
        alu_b     = imm_i;
        alu_op    = rv_pkg::ALU_ADD; // Also address add for LW/SW
        wsel      = rv_pkg::WSEL_NONE;
        mem_req   = 1'b0;
        mem_store = 1'b0;
        case (opcode)
            `OPC_OP: begin
                alu_b = rdata2;
                if (funct7 == `F7_BASE) begin
                    wsel = rv_pkg::WSEL_ALU;
                    case (funct3)
                        `F3_ADD_SUB: alu_op = rv_pkg::ALU_ADD;
                        `F3_SLT:     alu_op = rv_pkg::ALU_SLT;
                        `F3_XOR:     alu_op = rv_pkg::ALU_XOR;
                        `F3_OR:      alu_op = rv_pkg::ALU_OR;
                        `F3_AND:     alu_op = rv_pkg::ALU_AND;
                        default:     wsel   = rv_pkg::WSEL_NONE; // Shifts, SLTU
                    endcase
                end else if (funct7 == `F7_SUB && funct3 == `F3_ADD_SUB) begin
                    alu_op = rv_pkg::ALU_SUB;
                    wsel   = rv_pkg::WSEL_ALU;
                end
            end
            `OPC_OPIMM: begin
                if (funct3 == `F3_ADD_SUB) wsel = rv_pkg::WSEL_ALU; // ADDI only
            end
            `OPC_LUI: begin
                wsel = rv_pkg::WSEL_FETCH;
            end
            `OPC_LOAD: begin
                if (funct3 == `F3_LW) begin
                    wsel    = rv_pkg::WSEL_MEM;
                    mem_req = 1'b1;
                end
            end
            `OPC_STORE: begin
                if (funct3 == `F3_SW) begin
                    alu_b     = imm_s;
                    mem_req   = 1'b1;
                    mem_store = 1'b1;
                end
            end
            default: ; // No-op
        endcase
    end

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            rv_pkg::WAIT_INSTR: if (instr_valid) state_nxt = rv_pkg::EXECUTE;
            rv_pkg::EXECUTE:    state_nxt = mem_req ? rv_pkg::MEM_ACCESS : rv_pkg::WRITEBACK;
            rv_pkg::MEM_ACCESS: if (dbus_ack) state_nxt = rv_pkg::WRITEBACK; // Waits out slow memory
            rv_pkg::WRITEBACK:  state_nxt = rv_pkg::WAIT_INSTR;
            default:            state_nxt = rv_pkg::WAIT_INSTR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) state <= rv_pkg::WAIT_INSTR;
        else     state <= state_nxt;
    end

    // Data bus payload, address from the ALU add in EXECUTE
    always_ff @(posedge clk) begin
        if (state == rv_pkg::EXECUTE) begin
            dbus_adr   <= alu_result;
            dbus_dat_w <= rdata2;
        end
        if (state == rv_pkg::MEM_ACCESS && dbus_ack) begin
            load_data <= dbus_dat_r;
        end
    end

    assign dbus_cyc = (state == rv_pkg::MEM_ACCESS);
    assign dbus_stb = dbus_cyc;
    assign dbus_we  = dbus_cyc && mem_store;

    // Operand read on the cycle the word is first seen
    assign rs_en      = (state == rv_pkg::WAIT_INSTR) && instr_valid;
    assign rd_en      = (state == rv_pkg::WRITEBACK) && (wsel != rv_pkg::WSEL_NONE);
    assign fetch_next = (state == rv_pkg::WRITEBACK);

endmodule

`default_nettype wire

// ==== hdl/rv_fetch.sv ====
`default_nettype none

`include "rv_defines.svh"

module rv_fetch (
    input  logic          clk,
    input  logic          rst,

    input  logic          fetch_next,  // One-cycle pulse from the controller

    // Wishbone classic instruction master
    output logic          ibus_cyc,
    output logic          ibus_stb,
    output rv_pkg::addr_t ibus_adr,
    input  rv_pkg::word_t ibus_dat_r,
    input  logic          ibus_ack,

    output rv_pkg::word_t instr,       // Latched instruction word
    output logic          instr_valid, // Held until the next fetch_next
    output rv_pkg::word_t lui_value    // U-type immediate for the LUI write
);

    rv_pkg::addr_t pc;
    logic          req_open; // Bus request outstanding
    logic          boot;     // First cycle out of reset, kicks off the first read

    // Request machine and PC
    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= `RESET_PC;
            req_open    <= 1'b0;
            boot        <= 1'b1;
            instr_valid <= 1'b0;
        end else begin
            boot <= 1'b0;
            if (boot) begin
                req_open <= 1'b1; // Read RESET_PC, no increment
            end else if (fetch_next) begin
                pc          <= pc + 32'd4;
                req_open    <= 1'b1;
                instr_valid <= 1'b0; // Old word retires here
            end else if (req_open && ibus_ack) begin
                req_open    <= 1'b0; // cyc/stb drop next cycle
                instr_valid <= 1'b1;
            end
        end
    end

    // Instruction word, captured on the acknowledging edge
    always_ff @(posedge clk) begin
        if (req_open && ibus_ack) begin
            instr <= ibus_dat_r;
        end
    end

    // cyc and stb always move together
    assign ibus_cyc = req_open;
    assign ibus_stb = req_open;
    assign ibus_adr = pc;        // PC only changes with no request open

    // LUI writes the upper 20 bits, low bits cleared
    assign lui_value = {instr[31:12], 12'b0};

endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;    // Data or instruction word
    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [4:0]  reg_idx_t; // x0..x31

    // Register write source select, zero writes nothing
    typedef logic [1:0] wsel_t;

    localparam wsel_t WSEL_NONE  = 2'b00;
    localparam wsel_t WSEL_MEM   = 2'b01; // Load data
    localparam wsel_t WSEL_FETCH = 2'b10; // LUI upper immediate
    localparam wsel_t WSEL_ALU   = 2'b11;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT   // Signed compare, result is 0 or 1
    } alu_op_t;

    // Controller sequence for one instruction
    typedef enum logic [1:0] {
        WAIT_INSTR,
        EXECUTE,
        MEM_ACCESS,
        WRITEBACK
    } exec_state_t;

endpackage

`default_nettype wire

// ==== hdl/rv_registers.sv ====
`default_nettype none

`include "rv_defines.svh"

module rv_registers (
    input  logic             clk,
    input  logic             rst,

    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  logic             rs_en,       // Both read ports sample while high
    input  logic             rd_en,
    input  rv_pkg::wsel_t    wsel,        // Write source

    input  rv_pkg::word_t    wdata_mem,
    input  rv_pkg::word_t    wdata_fetch,
    input  rv_pkg::word_t    wdata_alu,

    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);

    rv_pkg::word_t regs [`NUM_REGS];
    rv_pkg::word_t wdata;

    // Write source select
    always_comb begin
        case (wsel)
            rv_pkg::WSEL_MEM:   wdata = wdata_mem;
            rv_pkg::WSEL_FETCH: wdata = wdata_fetch;
            rv_pkg::WSEL_ALU:   wdata = wdata_alu;
            default:            wdata = '0; // WSEL_NONE
        endcase
    end

    // x0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            rdata1 <= '0;
            rdata2 <= '0;
        end else begin
            if (rd_en && (rd != 5'd0)) begin
                regs[rd] <= wdata;
            end
            if (rs_en) begin // Otherwise both outputs hold
                rdata1 <= regs[rs1];
                rdata2 <= regs[rs2];
            end
        end
    end

endmodule

`default_nettype wire

// ==== include/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Register file depth
`define NUM_REGS 32

// First instruction address after reset
`define RESET_PC 32'h0000_0000

// Major opcodes, instr[6:0]
`define OPC_OP    7'b0110011 // R-type ALU
`define OPC_OPIMM 7'b0010011 // I-type ALU, only ADDI used
`define OPC_LUI   7'b0110111
`define OPC_LOAD  7'b0000011
`define OPC_STORE 7'b0100011

// funct3, instr[14:12]
`define F3_ADD_SUB 3'b000 // Also ADDI
`define F3_SLT     3'b010
`define F3_XOR     3'b100
`define F3_OR      3'b110
`define F3_AND     3'b111
`define F3_LW      3'b010
`define F3_SW      3'b010

// funct7, instr[31:25]
`define F7_BASE 7'b0000000
`define F7_SUB  7'b0100000

`endif

// ==== verif/rv_core_asserts.sv ====
`default_nettype none

module rv_core_asserts (
    input logic                clk,
    input logic                rst,
    input logic                ibus_cyc,
    input logic                ibus_stb,
    input rv_pkg::addr_t       ibus_adr,
    input logic                ibus_ack,
    input logic                dbus_cyc,
    input logic                dbus_stb,
    input logic                dbus_we,
    input rv_pkg::addr_t       dbus_adr,
    input logic                dbus_ack,
    input logic                rd_en,
    input rv_pkg::wsel_t       wsel,
    input rv_pkg::exec_state_t state  // Controller FSM
);

    int failures = 0; // Read by the testbench at the end

    // Classic handshake, request and address held until ack
    ibus_hold: assert property (@(posedge clk) disable iff (rst)
        ibus_stb && !ibus_ack |=> ibus_stb && $stable(ibus_adr))
        else begin
            $error("ibus request changed before ack");
            failures++;
        end

    dbus_hold: assert property (@(posedge clk) disable iff (rst)
        dbus_stb && !dbus_ack |=> dbus_stb && $stable(dbus_adr) && $stable(dbus_we))
        else begin
            $error("dbus request changed before ack");
            failures++;
        end

    // Ack only inside a cycle, and the master lets go on the next one
    ibus_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        ibus_ack |-> ibus_cyc ##1 !ibus_cyc)
        else begin
            $error("ibus ack without cyc, or cyc held after ack");
            failures++;
        end

    dbus_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        dbus_ack |-> dbus_cyc ##1 !dbus_cyc)
        else begin
            $error("dbus ack without cyc, or cyc held after ack");
            failures++;
        end

    // Memory write source only right after a finished data read
    load_write_source: assert property (@(posedge clk) disable iff (rst)
        rd_en && (wsel == rv_pkg::WSEL_MEM) |->
            $past(state == rv_pkg::MEM_ACCESS && dbus_ack && !dbus_we))
        else begin
            $error("load write-back without a completed data read");
            failures++;
        end

    bus_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(ibus_cyc && dbus_cyc))
        else begin
            $error("ibus and dbus cycles overlap");
            failures++;
        end

endmodule

bind rv_core rv_core_asserts asserts_i (
    .clk, .rst,
    .ibus_cyc, .ibus_stb, .ibus_adr, .ibus_ack,
    .dbus_cyc, .dbus_stb, .dbus_we, .dbus_adr, .dbus_ack,
    .rd_en, .wsel,
    .state (ctrl_i.state)
);

`default_nettype wire

// ==== verif/rv_core_tb.sv ====
`default_nettype none

`include "rv_defines.svh"

module rv_core_tb;

    localparam int TEST_INSTRS    = 16 + 4 + 5 + 4 + 4 + 3; // Program lengths of all tests
    localparam int TIMEOUT_CYCLES = TEST_INSTRS * 40;        // Three memory waits plus overhead

    logic          clk;
    logic          rst;
    logic          ibus_cyc, ibus_stb, ibus_ack;
    rv_pkg::addr_t ibus_adr;
    rv_pkg::word_t ibus_dat_r;
    logic          dbus_cyc, dbus_stb, dbus_we, dbus_ack;
    rv_pkg::addr_t dbus_adr;
    rv_pkg::word_t dbus_dat_w, dbus_dat_r;

    rv_pkg::word_t imem [256];
    rv_pkg::word_t dmem [256];
    int            prog_len;
    rv_pkg::addr_t iadr_q [$];    // Fetch addresses acknowledged since reset
    rv_pkg::addr_t wr_addr_q [$]; // Data writes in order
    rv_pkg::word_t wr_data_q [$];
    logic [31:0]   seed = 32'h3b2f;
    int            iwait = 0;     // Cycles left before the next ack
    int            dwait = 0;
    int            error_count, pass_count, fail_count;

    rv_core dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int wait_draw();
        logic [31:0] r;
        r = lcg_next();
        return int'(r[17:16]); // 0 to 3 cycles
    endfunction

    // RV32I encoders
    function automatic rv_pkg::word_t enc_r(logic [6:0] f7, logic [2:0] f3, rv_pkg::reg_idx_t rd,
                                            rv_pkg::reg_idx_t rs1, rv_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic rv_pkg::word_t enc_i(logic [6:0] opc, logic [2:0] f3, rv_pkg::reg_idx_t rd,
                                            rv_pkg::reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc}; // ADDI and LW
    endfunction

    function automatic rv_pkg::word_t enc_s(rv_pkg::reg_idx_t rs2, rv_pkg::reg_idx_t rs1,
                                            logic [11:0] imm);
        return {imm[11:5], rs2, rs1, `F3_SW, imm[4:0], `OPC_STORE};
    endfunction

    function automatic rv_pkg::word_t enc_u(rv_pkg::reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, `OPC_LUI};
    endfunction

    // Past the program end the core sees ADDI x0,x0,0
    function automatic rv_pkg::word_t imem_read(rv_pkg::addr_t adr);
        if (int'(adr[31:2]) >= prog_len) begin
            return enc_i(`OPC_OPIMM, `F3_ADD_SUB, 5'd0, 5'd0, 12'h000);
        end
        return imem[adr[9:2]];
    endfunction

    function automatic rv_pkg::word_t fill_value(rv_pkg::addr_t adr);
        return (adr * 32'h9e37_79b1) ^ 32'h5bd1_e995; // Odd multiplier, every address differs
    endfunction

    // Instruction memory, ack only while a request is open
    always @(posedge clk) begin
        #2;
        if (ibus_ack) begin
            ibus_ack = 1'b0;
            iwait    = wait_draw(); // Latency of the next request
        end else if (ibus_cyc && ibus_stb) begin
            if (iwait == 0) begin
                ibus_dat_r = imem_read(ibus_adr);
                ibus_ack   = 1'b1;
                iadr_q.push_back(ibus_adr);
            end else begin
                iwait--;
            end
        end
    end

    // Data memory, writes also go to the check queues
    always @(posedge clk) begin
        #2;
        if (dbus_ack) begin
            dbus_ack = 1'b0;
            dwait    = wait_draw();
        end else if (dbus_cyc && dbus_stb) begin
            if (dwait == 0) begin
                if (dbus_we) begin
                    dmem[dbus_adr[9:2]] = dbus_dat_w;
                    wr_addr_q.push_back(dbus_adr);
                    wr_data_q.push_back(dbus_dat_w);
                end else begin
                    dbus_dat_r = dmem[dbus_adr[9:2]];
                end
                dbus_ack = 1'b1;
            end else begin
                dwait--;
            end
        end
    end

    task automatic check_word(string name, rv_pkg::word_t want, rv_pkg::word_t got);
        if (got !== want) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, want, got);
            error_count++;
        end
    endtask

    task automatic check_addr(string name, rv_pkg::addr_t want, rv_pkg::addr_t got);
        if (got !== want) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, want, got);
            error_count++;
        end
    endtask

    task automatic check_store(int k, rv_pkg::addr_t adr, rv_pkg::word_t dat);
        check_addr("dbus_adr", adr, wr_addr_q[k]);
        check_word("dbus_dat_w", dat, wr_data_q[k]);
    endtask

    // Returns one edge into reset, core idle, memories free to reload
    task automatic start_reset();
        @(posedge clk);
        #2 rst = 1'b1;
        @(posedge clk);
        #2;
        prog_len = 0;
    endtask

    task automatic finish_reset();
        repeat (7) @(posedge clk); // 8 edges with rst high in total
        #2;
        iadr_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        rst = 1'b0;
    endtask

    task automatic put_instr(rv_pkg::word_t w);
        imem[prog_len[7:0]] = w;
        prog_len++;
    endtask

    task automatic wait_writes(int count);
        while (wr_data_q.size() < count) @(posedge clk); // Watchdog bounds this
    endtask

    task automatic end_test(string name, int errs_before);
        if (error_count == errs_before) begin
            $display("Test %s passed", name);
            pass_count++;
        end else begin
            $display("Test %s failed with %0d errors", name, error_count - errs_before);
            fail_count++;
        end
    endtask

    task automatic test_arith();
        int            errs;
        logic [31:0]   r;
        logic [11:0]   ia;
        logic [11:0]   ib;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t want [7];
        errs = error_count;
        r  = lcg_next();
        ia = {1'b1, r[10:0]};  // Negative
        r  = lcg_next();
        ib = {1'b0, r[26:16]}; // Positive, so a signed SLT differs from unsigned
        a  = {{20{ia[11]}}, ia};
        b  = {{20{ib[11]}}, ib};
        want[0] = a + b;
        want[1] = a - b;
        want[2] = a & b;
        want[3] = a | b;
        want[4] = a ^ b;
        want[5] = 32'd1; // Negative a below positive b
        want[6] = 32'd0;
        start_reset();
        put_instr(enc_i(`OPC_OPIMM, `F3_ADD_SUB, 5'd1, 5'd0, ia));
        put_instr(enc_i(`OPC_OPIMM, `F3_ADD_SUB, 5'd2, 5'd0, ib));
        put_instr(enc_r(`F7_BASE, `F3_ADD_SUB, 5'd3, 5'd1, 5'd2));
        put_instr(enc_r(`F7_SUB, `F3_ADD_SUB, 5'd4, 5'd1, 5'd2));
        put_instr(enc_r(`F7_BASE, `F3_AND, 5'd5, 5'd1, 5'd2));
        put_instr(enc_r(`F7_BASE, `F3_OR, 5'd6, 5'd1, 5'd2));
        put_instr(enc_r(`F7_BASE, `F3_XOR, 5'd7, 5'd1, 5'd2));
        put_instr(enc_r(`F7_BASE, `F3_SLT, 5'd8, 5'd1, 5'd2));
        put_instr(enc_r(`F7_BASE, `F3_SLT, 5'd9, 5'd2, 5'd1)); // Operands swapped
        for (int k = 0; k < 7; k++) begin
            put_instr(enc_s(rv_pkg::reg_idx_t'(3 + k), 5'd0, 12'h200 + 12'(4 * k)));
        end
        finish_reset();
        wait_writes(7);
        for (int k = 0; k < 7; k++) begin
            check_store(k, 32'h200 + 32'(4 * k), want[k]);
        end
        end_test("arith", errs);
    endtask

    task automatic test_lui();
        int          errs;
        logic [31:0] r;
        logic [19:0] u1;
        logic [19:0] u2;
        errs = error_count;
        r  = lcg_next();
        u1 = r[31:12];
        u2 = r[19:0] | 20'h80000; // Top bit set
        start_reset();
        put_instr(enc_u(5'd10, u1));
        put_instr(enc_u(5'd11, u2));
        put_instr(enc_s(5'd10, 5'd0, 12'h300));
        put_instr(enc_s(5'd11, 5'd0, 12'h304));
        finish_reset();
        wait_writes(2);
        check_store(0, 32'h300, {u1, 12'h000});
        check_store(1, 32'h304, {u2, 12'h000});
        end_test("lui", errs);
    endtask

    task automatic test_loads();
        int errs;
        errs = error_count;
        start_reset();
        for (int i = 0; i < 256; i++) begin
            dmem[i[7:0]] = fill_value({22'b0, i[7:0], 2'b00});
        end
        put_instr(enc_i(`OPC_OPIMM, `F3_ADD_SUB, 5'd1, 5'd0, 12'h100)); // Base 0x100
        put_instr(enc_i(`OPC_LOAD, `F3_LW, 5'd2, 5'd1, 12'h020));
        put_instr(enc_i(`OPC_LOAD, `F3_LW, 5'd3, 5'd1, 12'hff0));       // -16
        put_instr(enc_s(5'd2, 5'd1, 12'h040));
        put_instr(enc_s(5'd3, 5'd1, 12'hff8));                          // -8
        finish_reset();
        wait_writes(2);
        check_store(0, 32'h140, fill_value(32'h120));
        check_store(1, 32'h0f8, fill_value(32'h0f0));
        end_test("loads", errs);
    endtask

    task automatic test_x0();
        int errs;
        errs = error_count;
        start_reset();
        put_instr(enc_i(`OPC_OPIMM, `F3_ADD_SUB, 5'd0, 5'd0, 12'h123)); // Dropped write
        put_instr(enc_s(5'd0, 5'd0, 12'h200));
        put_instr(enc_s(5'd5, 5'd0, 12'h204));  // Written before this reset only
        put_instr(enc_s(5'd31, 5'd0, 12'h208)); // Never written
        finish_reset();
        wait_writes(3);
        check_store(0, 32'h200, 32'h0);
        check_store(1, 32'h204, 32'h0);
        check_store(2, 32'h208, 32'h0);
        end_test("x0", errs);
    endtask

    task automatic test_reset_restart();
        int errs;
        errs = error_count;
        start_reset();
        put_instr(enc_i(`OPC_OPIMM, `F3_ADD_SUB, 5'd1, 5'd0, 12'h055));
        put_instr(enc_s(5'd1, 5'd0, 12'h200));
        put_instr(enc_s(5'd1, 5'd0, 12'h204));
        finish_reset();
        wait_writes(1);
        check_store(0, 32'h200, 32'h55);
        start_reset(); // Lands while the core is still running
        put_instr(enc_s(5'd1, 5'd0, 12'h208));
        finish_reset();
        wait_writes(1);
        check_addr("ibus_adr", `RESET_PC, iadr_q[0]);
        check_store(0, 32'h208, 32'h0); // x1 cleared by the reset
        end_test("reset_restart", errs);
    endtask

    task automatic test_unknown_op();
        int errs;
        errs = error_count;
        start_reset();
        put_instr(enc_i(`OPC_OPIMM, `F3_ADD_SUB, 5'd1, 5'd0, 12'h03a));
        put_instr({12'h7ff, 5'd1, 3'b000, 5'd1, 7'b0001011}); // ADDI shape, unused opcode
        put_instr(enc_s(5'd1, 5'd0, 12'h210));
        finish_reset();
        wait_writes(1);
        check_store(0, 32'h210, 32'h3a);
        for (int k = 0; k < 3; k++) begin
            check_addr("ibus_adr", `RESET_PC + 32'(4 * k), iadr_q[k]);
        end
        end_test("unknown_op", errs);
    endtask

    // Watchdog
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the DUT did not finish the tests within %0d cycles", cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        ibus_ack    = 1'b0;
        ibus_dat_r  = '0;
        dbus_ack    = 1'b0;
        dbus_dat_r  = '0;
        prog_len    = 0;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        test_arith();
        test_lui();
        test_loads();
        test_x0();
        test_reset_restart();
        test_unknown_op();
        $display("Tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 pass_count, fail_count, error_count, dut_i.asserts_i.failures);
        if (fail_count == 0 && error_count == 0 && dut_i.asserts_i.failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
